//--- Bender.yml
package:
  name: uart_echo

sources:
  - logic/uart_pkg.sv
  - logic/uart_buf_pkg.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/uart_ring_buf.sv
  - logic/uart_echo_top.sv
  - target: test
    files:
      - bench/uart_echo_asserts.sv
      - bench/tb_uart_echo.sv

//--- bench/tb_uart_echo.sv
// Testbench for the UART echo peripheral
// Case table, serial frame driver, echo monitor and result checks
module tb_uart_echo;

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import uart_buf_pkg::*;

  localparam int unsigned MAX_BYTES     = 10;
  localparam int unsigned NUM_CASES     = 5;
  localparam int unsigned QUIET_CYCLES  = 20 * CYCLES_PER_SYMBOL;  // Monitor wait limit
  localparam int unsigned GLITCH_CYCLES = HALF_SYMBOL / 2;

  typedef enum logic [1:0] {FRM_NORMAL, FRM_BAD_STOP, FRM_GLITCH} frame_kind_e;

  typedef struct {
    string                     name;
    frame_kind_e               kind;     // Shape of the first frame, the rest are normal
    int                        n_tx;
    logic [0:MAX_BYTES-1][7:0] tx;
    logic                      hold;
    int                        n_exp;
    logic [0:MAX_BYTES-1][7:0] exp;
    logic                      exp_ovf;
  } test_case_t;

  logic       clk;
  logic       rst_n;
  logic       rx_line;
  logic       tx_hold;
  logic       tx_line;
  logic       overflow;
  logic       driving;
  int         errors;
  int         passed;
  uart_byte_t echoed [$];
  test_case_t cases [NUM_CASES];

  uart_echo_top u_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .rx_i       (rx_line),
    .tx_hold_i  (tx_hold),
    .tx_o       (tx_line),
    .overflow_o (overflow)
  );

  always #20 clk = ~clk;

  task automatic wait_symbols(input int unsigned n);
    repeat (n * CYCLES_PER_SYMBOL) @(negedge clk);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n   = 1'b0;
    rx_line = 1'b1;
    tx_hold = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic send_frame(input uart_byte_t data, input frame_kind_e kind);
    logic [FRAME_BITS-1:0] bits;
    bits = {kind != FRM_BAD_STOP, data, 1'b0};  // Start bit goes out first
    if (kind == FRM_GLITCH) begin
      rx_line = 1'b0;
      repeat (GLITCH_CYCLES) @(negedge clk);
      rx_line = 1'b1;
      wait_symbols(1);
    end else begin
      for (int i = 0; i < FRAME_BITS; i++) begin
        rx_line = bits[i];
        wait_symbols(1);
      end
      rx_line = 1'b1;
      if (kind == FRM_BAD_STOP) begin
        wait_symbols(1);  // Receiver rejects the tail of the low stop bit
      end
    end
  endtask

  // Decodes tx_o at mid-bit until the line stays quiet after the driver is done
  task automatic capture_echoes();
    int unsigned quiet;
    uart_byte_t  data;
    echoed.delete();
    forever begin
      quiet = 0;
      while (tx_line && quiet < QUIET_CYCLES) begin
        @(negedge clk);
        quiet = driving ? 0 : quiet + 1;
      end
      if (tx_line) begin
        return;
      end
      repeat (HALF_SYMBOL) @(negedge clk);
      assert (!tx_line) else begin
        $display("Echoed start bit %0d ended before mid-bit", echoed.size());
        errors++;
      end
      for (int i = 0; i < DATA_BITS; i++) begin
        repeat (CYCLES_PER_SYMBOL) @(negedge clk);
        data[i] = tx_line;
      end
      repeat (CYCLES_PER_SYMBOL) @(negedge clk);
      assert (tx_line) else begin
        $display("Echoed byte %0d has a low stop bit", echoed.size());
        errors++;
      end
      echoed.push_back(data);
    end
  endtask

  task automatic check_results(input test_case_t tc);
    int n_cmp;
    assert (echoed.size() >= tc.n_exp) else begin
      $display("%s timed out after %0d of %0d echoed bytes", tc.name, echoed.size(), tc.n_exp);
      errors++;
    end
    assert (echoed.size() <= tc.n_exp) else begin
      $display("ERR %s echo count: expected %0d, actual %0d", tc.name, tc.n_exp, echoed.size());
      errors++;
    end
    n_cmp = (echoed.size() < tc.n_exp) ? echoed.size() : tc.n_exp;
    for (int i = 0; i < n_cmp; i++) begin
      assert (echoed[i] == tc.exp[i]) else begin
        $display("ERR %s byte %0d: expected %02h, actual %02h", tc.name, i, tc.exp[i], echoed[i]);
        errors++;
      end
    end
    assert (overflow == tc.exp_ovf) else begin
      $display("ERR %s overflow_o: expected %0b, actual %0b", tc.name, tc.exp_ovf, overflow);
      errors++;
    end
  endtask

  task automatic run_case(input test_case_t tc);
    int unsigned gap;
    int          errors_before;
    int unsigned fails_before;
    errors_before = errors;
    fails_before  = u_dut.u_asserts.fails;
    apply_reset();
    driving = 1'b1;
    tx_hold = tc.hold;
    fork
      begin
        for (int i = 0; i < tc.n_tx; i++) begin
          gap = $urandom % 4;
          wait_symbols(gap);
          send_frame(tc.tx[i], (i == 0) ? tc.kind : FRM_NORMAL);
        end
        tx_hold = 1'b0;  // Queued bytes drain from here
        driving = 1'b0;
      end
      capture_echoes();
    join
    check_results(tc);
    assert (u_dut.u_asserts.fails == fails_before) else begin
      $display("%s tripped %0d concurrent assertions", tc.name,
               u_dut.u_asserts.fails - fails_before);
      errors++;
    end
    if (errors == errors_before) begin
      passed++;
      $display("case %s ok", tc.name);
    end else begin
      $display("case %s FAIL", tc.name);
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    rx_line = 1'b1;
    tx_hold = 1'b0;
    driving = 1'b0;
    errors  = 0;
    passed  = 0;
    void'($urandom(32'h7300_7432));
    cases[0] = '{name: "idle_after_reset", kind: FRM_NORMAL, n_tx: 0, tx: '0,
                 hold: 1'b0, n_exp: 0, exp: '0, exp_ovf: 1'b0};
    cases[1] = '{name: "echo_order", kind: FRM_NORMAL, n_tx: 5,
                 tx: {8'h00, 8'hFF, 8'hA5, 8'h5A, 8'h41, 40'h0}, hold: 1'b0, n_exp: 5,
                 exp: {8'h00, 8'hFF, 8'hA5, 8'h5A, 8'h41, 40'h0}, exp_ovf: 1'b0};
    cases[2] = '{name: "bad_stop", kind: FRM_BAD_STOP, n_tx: 2,
                 tx: {8'hC3, 8'h96, 64'h0}, hold: 1'b0, n_exp: 1,
                 exp: {8'h96, 72'h0}, exp_ovf: 1'b0};
    cases[3] = '{name: "start_glitch", kind: FRM_GLITCH, n_tx: 2,
                 tx: {8'h00, 8'h3C, 64'h0}, hold: 1'b0, n_exp: 1,
                 exp: {8'h3C, 72'h0}, exp_ovf: 1'b0};
    cases[4] = '{name: "hold_overflow", kind: FRM_NORMAL, n_tx: 10,
                 tx: {80'h10_11_12_13_14_15_16_17_18_19}, hold: 1'b1, n_exp: BUF_DEPTH,
                 exp: {64'h10_11_12_13_14_15_16_17, 16'h0}, exp_ovf: 1'b1};
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(cases[i]);
    end
    $display("%0d of %0d cases passed, %0d errors", passed, NUM_CASES, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- bench/uart_echo_asserts.sv
// Concurrent checks on the echo datapath, bound into uart_echo_top
// Idle line level, strobe spacing, no read from an empty buffer
module uart_echo_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  tx_line_i,
  input logic                  tx_idle_i,
  input uart_buf_pkg::buf_wr_t rx_wr_i,
  input uart_buf_pkg::buf_rd_t tx_rd_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;
  import uart_buf_pkg::*;

  localparam int unsigned WR_GAP = (FRAME_BITS - 1) * CYCLES_PER_SYMBOL;

  int unsigned        fails = 0;
  logic [BUF_PTR_W:0] level_q;  // Bytes held, tracked from the strobes alone

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      level_q <= '0;
    end else if (tx_rd_i.valid) begin
      level_q <= level_q - 1'b1;
    end else if (rx_wr_i.valid && level_q != (BUF_PTR_W + 1)'(BUF_DEPTH)) begin
      level_q <= level_q + 1'b1;
    end
  end

  idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_idle_i |-> tx_line_i)
    else begin
      $error("tx_o is low while the transmitter is idle");
      fails++;
    end

  // Receiver writes at most once per frame
  wr_once_per_frame: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_wr_i.valid |=> !rx_wr_i.valid [*WR_GAP])
    else begin
      $error("Receiver wrote twice within one frame");
      fails++;
    end

  rd_strobe_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_rd_i.valid |=> !tx_rd_i.valid)
    else begin
      $error("Buffer read strobe lasted more than one cycle");
      fails++;
    end

  // Oldest byte only exists while the ring holds something
  rd_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_rd_i.valid |-> level_q != '0)
    else begin
      $error("Read strobe issued while the buffer is empty");
      fails++;
    end

endmodule

bind uart_echo_top uart_echo_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .tx_line_i (tx_o),
  .tx_idle_i (tx_idle),
  .rx_wr_i   (rx_wr),
  .tx_rd_i   (tx_rd)
);

//--- logic/uart_buf_pkg.sv
// Ring buffer geometry and the transfer structs on both sides of it
// Write from the receiver, read handed to the transmitter
package uart_buf_pkg;

  localparam int unsigned BUF_DEPTH = 8;
  localparam int unsigned BUF_PTR_W = 3;  // Pointers wrap at BUF_DEPTH

  // Receiver write, valid is a one-cycle strobe
  typedef struct packed {
    logic                 valid;
    uart_pkg::uart_byte_t data;
  } buf_wr_t;

  // Oldest byte handed to the transmitter
  typedef struct packed {
    logic                 valid;
    uart_pkg::uart_byte_t data;
  } buf_rd_t;

endpackage

//--- logic/uart_echo_top.sv
// UART echo peripheral
// Receiver feeds the ring buffer, transmitter drains it
module uart_echo_top (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rx_i,
  input  logic tx_hold_i,
  output logic tx_o,
  output logic overflow_o
);

  import uart_buf_pkg::*;

  buf_wr_t rx_wr;
  buf_rd_t tx_rd;
  logic    tx_idle;

  uart_rx u_rx (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rx_i    (rx_i),
    .rx_wr_o (rx_wr)
  );

  uart_ring_buf u_buf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_i       (rx_wr),
    .tx_idle_i  (tx_idle),
    .rd_o       (tx_rd),
    .overflow_o (overflow_o)
  );

  uart_tx u_tx (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tx_hold_i (tx_hold_i),
    .tx_rd_i   (tx_rd),
    .tx_idle_o (tx_idle),
    .tx_o      (tx_o)
  );

endmodule

//--- logic/uart_pkg.sv
// Serial line timing for the echo peripheral
// Symbol period, mid-bit offset, frame layout and the data byte type
package uart_pkg;

  localparam int unsigned CYCLES_PER_SYMBOL = 16;                    // Clocks per serial bit
  localparam int unsigned HALF_SYMBOL       = CYCLES_PER_SYMBOL / 2; // Mid-bit sample point
  localparam int unsigned FRAME_BITS        = 10;                    // Start, data, stop
  localparam int unsigned DATA_BITS         = 8;

  // Counter widths
  localparam int unsigned SYM_CNT_W = $clog2(CYCLES_PER_SYMBOL);
  localparam int unsigned BIT_CNT_W = $clog2(FRAME_BITS);

  // Frame bit positions, data sits between them LSB first
  localparam int unsigned START_POS = 0;
  localparam int unsigned STOP_POS  = FRAME_BITS - 1;

  typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

//--- logic/uart_ring_buf.sv
// Eight-entry ring buffer on single-port storage
// Write/read arbitration and the sticky overflow flag
module uart_ring_buf (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  uart_buf_pkg::buf_wr_t wr_i,
  input  logic                  tx_idle_i,
  output uart_buf_pkg::buf_rd_t rd_o,
  output logic                  overflow_o
);

  import uart_pkg::*;
  import uart_buf_pkg::*;

  uart_byte_t           mem_q [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr_q;
  logic [BUF_PTR_W-1:0] rd_ptr_q;
  logic [BUF_PTR_W:0]   count_q;
  logic                 overflow_q;

  logic                 full;
  logic                 empty;
  logic                 rd_req;
  logic                 wr_grant;
  logic                 rd_grant;
  logic [BUF_PTR_W-1:0] port_addr;

  assign full  = (count_q == (BUF_PTR_W + 1)'(BUF_DEPTH));
  assign empty = (count_q == '0);

  // Fixed priority, a write strobe owns the port and a pending read waits a cycle
  assign rd_req    = tx_idle_i && !empty;
  assign wr_grant  = wr_i.valid && !full;
  assign rd_grant  = rd_req && !wr_i.valid;
  assign port_addr = wr_i.valid ? wr_ptr_q : rd_ptr_q;

  always_ff @(posedge clk_i) begin
    if (wr_grant) begin
      mem_q[port_addr] <= wr_i.data;
    end
  end

  assign rd_o = '{valid: rd_grant, data: mem_q[port_addr]};

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_grant) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_grant) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (wr_grant) begin
        count_q <= count_q + 1'b1;
      end else if (rd_grant) begin
        count_q <= count_q - 1'b1;
      end
      if (wr_i.valid && full) begin
        overflow_q <= 1'b1;  // Byte lost, held until reset
      end
    end
  end

  assign overflow_o = overflow_q;

endmodule

//--- logic/uart_rx.sv
// Serial receiver with start-bit glitch rejection and stop-bit check
// Emits a one-cycle write strobe for each correctly framed byte
module uart_rx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rx_i,
  output uart_buf_pkg::buf_wr_t rx_wr_o
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e            state_q;
  logic [SYM_CNT_W-1:0] cyc_q;
  logic [BIT_CNT_W-1:0] bit_q;
  uart_byte_t           shift_q;
  logic                 wr_valid_q;
  logic                 sym_end;

  assign sym_end = (cyc_q == SYM_CNT_W'(CYCLES_PER_SYMBOL - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= RX_IDLE;
      cyc_q      <= '0;
      bit_q      <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= 1'b0;
      cyc_q      <= sym_end ? '0 : cyc_q + 1'b1;
      unique case (state_q)
        RX_IDLE: begin
          cyc_q <= '0;
          if (!rx_i) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (cyc_q == SYM_CNT_W'(HALF_SYMBOL - 1)) begin
            cyc_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_i ? RX_IDLE : RX_DATA;  // High at mid-bit is a glitch
          end
        end
        RX_DATA: begin
          if (sym_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == BIT_CNT_W'(DATA_BITS - 1)) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (sym_end) begin
            wr_valid_q <= rx_i;  // Low stop bit drops the byte
            state_q    <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data arrives LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && sym_end) begin
      shift_q <= {rx_i, shift_q[DATA_BITS-1:1]};
    end
  end

  assign rx_wr_o = '{valid: wr_valid_q, data: shift_q};

endmodule

//--- logic/uart_tx.sv
// Serial transmitter, one 10-bit frame per byte from the ring buffer
// Idle level is reported back so the buffer knows when to hand over a byte
module uart_tx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tx_hold_i,
  input  uart_buf_pkg::buf_rd_t tx_rd_i,
  output logic                  tx_idle_o,
  output logic                  tx_o
);

  import uart_pkg::*;

  logic                  active_q;
  logic [SYM_CNT_W-1:0]  cyc_q;
  logic [BIT_CNT_W-1:0]  bit_q;
  logic [FRAME_BITS-1:0] frame_q;
  logic [FRAME_BITS-1:0] frame_load;

  always_comb begin
    frame_load                         = '1;
    frame_load[START_POS]              = 1'b0;
    frame_load[STOP_POS-1:START_POS+1] = tx_rd_i.data;
    frame_load[STOP_POS]               = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cyc_q    <= '0;
      bit_q    <= '0;
      frame_q  <= '1;  // Line idles high
    end else if (!active_q) begin
      if (tx_rd_i.valid) begin
        frame_q  <= frame_load;
        active_q <= 1'b1;
        cyc_q    <= '0;
        bit_q    <= '0;
      end
    end else if (cyc_q == SYM_CNT_W'(CYCLES_PER_SYMBOL - 1)) begin
      cyc_q   <= '0;
      frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};  // Refill with idle level
      if (bit_q == BIT_CNT_W'(STOP_POS)) begin
        active_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  assign tx_o      = frame_q[START_POS];
  assign tx_idle_o = !active_q && !tx_hold_i;  // Hold keeps the buffer from handing over

endmodule

//--- uart_echo_top.f
logic/uart_pkg.sv
logic/uart_buf_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_ring_buf.sv
logic/uart_echo_top.sv
bench/uart_echo_asserts.sv
bench/tb_uart_echo.sv
